// File: common/cnn_defs.svh
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// ------------------------------------------------------------
// Bus and arithmetic widths
// ------------------------------------------------------------
`define CNN_ADDR_W 12
`define CNN_DATA_W 16
`define CNN_PIXEL_W 8
`define CNN_ACC_W 20

// Size word that closes the matrix list
`define CNN_TERMINATOR 16'hFFFF

// ------------------------------------------------------------
// Convolution geometry
// ------------------------------------------------------------
`define CNN_KERNEL_TAPS 9
// Two pixels per word, so 4x4 pixels take 8 words
`define CNN_PATCH_WORDS 8

// Patch slots held by the engine
`define CNN_PATCH_CREDITS 1

// Upper ReLU clamp for an output byte
`define CNN_RELU_MAX 127

`endif

// File: common/cnn_pkg.sv
`include "cnn_defs.svh"

package cnn_pkg;

	// ------------------------------------------------------------
	// SRAM side
	// ------------------------------------------------------------
	typedef logic [`CNN_ADDR_W-1:0] addr_t;
	typedef logic [`CNN_DATA_W-1:0] word_t;

	// ------------------------------------------------------------
	// Datapath
	// ------------------------------------------------------------
	// Pixels and kernel weights are both signed bytes
	typedef logic signed [`CNN_PIXEL_W-1:0] pixel_t;

	// Room for nine byte products with headroom
	typedef logic signed [`CNN_ACC_W-1:0] acc_t;

	// One sum per window of the 2x2 output block
	// Index 0 is offset (0,0), 1 is (0,1), 2 is (1,0), 3 is (1,1)
	typedef acc_t [3:0] acc_quad_t;

endpackage

// File: common/patch_if.sv
`timescale 1ns/1ps

interface patch_if;

	// Patch words, one per cycle, eight per patch
	logic word_valid;
	cnn_pkg::word_t word;
	logic patch_last;

	// Pulse once the last patch of a matrix is out
	logic matrix_end;

	// Engine frees a patch slot
	logic credit_return;

	modport source (
		output word_valid,
		output word,
		output patch_last,
		output matrix_end,
		input  credit_return
	);

	modport sink (
		input  word_valid,
		input  word,
		input  patch_last,
		input  matrix_end,
		output credit_return
	);

endinterface

// File: fetch/patch_fetcher.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module patch_fetcher (
	input  logic clk,
	input  logic reset_b,
	input  logic run,
	output logic busy,
	output cnn_pkg::addr_t in_addr,
	input  cnn_pkg::word_t in_data,
	input  logic matrix_written,
	patch_if.source patch
);

	localparam int CREDIT_W = $clog2(`CNN_PATCH_CREDITS + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SIZE_RD,
		ST_SIZE_CHK,
		ST_READ,
		ST_DONE
	} state_t;

	state_t state;
	cnn_pkg::addr_t base;
	cnn_pkg::addr_t patch_addr;
	cnn_pkg::addr_t word_off;
	cnn_pkg::addr_t mat_words;
	logic [6:0] n;
	logic [2:0] log_n;
	logic [2:0] size_log;
	logic [6:0] row;
	logic [6:0] col;
	logic [2:0] word_idx;
	logic [CREDIT_W-1:0] credits;
	logic [`CNN_ADDR_W-1:0] started;
	logic [`CNN_ADDR_W-1:0] written;
	logic issue;
	logic take;
	logic last_word;
	logic col_last;
	logic row_last;
	logic word_valid_q;
	logic patch_last_q;
	logic mend_d;
	logic matrix_end_q;

	assign busy = (state != ST_IDLE);

	// N is a power of two from 4 to 64
	always_comb begin
		case (in_data[6:0])
			7'd8:    size_log = 3'd3;
			7'd16:   size_log = 3'd4;
			7'd32:   size_log = 3'd5;
			7'd64:   size_log = 3'd6;
			default: size_log = 3'd2;
		endcase
	end

	// ------------------------------------------------------------
	// Address generation
	// ------------------------------------------------------------
	// First word of the patch at (row, col), past the size word
	assign patch_addr = base + cnn_pkg::addr_t'(1) +
		(((cnn_pkg::addr_t'(row) << log_n) + cnn_pkg::addr_t'(col)) >> 1);

	// Patch rows sit N/2 words apart
	assign word_off = (cnn_pkg::addr_t'(word_idx[2:1]) << (log_n - 3'd1)) +
		cnn_pkg::addr_t'(word_idx[0]);

	// N*N/2 data words in this matrix
	assign mat_words = cnn_pkg::addr_t'(1) << ({log_n, 1'b0} - 4'd1);

	// A patch only starts with a free slot in the engine
	assign issue = (state == ST_READ) && ((word_idx != 3'd0) || (credits != '0));
	assign take = issue && (word_idx == 3'd0);
	assign last_word = (word_idx == 3'(`CNN_PATCH_WORDS - 1));
	// Last 4x4 patch starts at N-4
	assign col_last = ((col + 7'd4) == n);
	assign row_last = ((row + 7'd4) == n);

	always_comb begin
		in_addr = base;
		if (state == ST_READ) begin
			in_addr = patch_addr + word_off;
		end
	end

	// ------------------------------------------------------------
	// Run control and matrix walk
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state <= ST_IDLE;
			base <= '0;
			n <= 7'd4;
			log_n <= 3'd2;
			row <= '0;
			col <= '0;
			word_idx <= '0;
			started <= '0;
			written <= '0;
		end else begin
			if (matrix_written) begin
				written <= written + 1'b1;
			end
			case (state)
				ST_IDLE: begin
					base <= '0;
					started <= '0;
					written <= '0;
					if (run) begin
						state <= ST_SIZE_RD;
					end
				end
				ST_SIZE_RD: begin
					state <= ST_SIZE_CHK;
				end
				ST_SIZE_CHK: begin
					if (in_data == `CNN_TERMINATOR) begin
						state <= ST_DONE;
					end else begin
						n <= in_data[6:0];
						log_n <= size_log;
						row <= '0;
						col <= '0;
						word_idx <= '0;
						started <= started + 1'b1;
						state <= ST_READ;
					end
				end
				ST_READ: begin
					if (issue) begin
						word_idx <= word_idx + 3'd1;
						if (last_word) begin
							word_idx <= '0;
							if (!col_last) begin
								col <= col + 7'd2;
							end else if (!row_last) begin
								col <= '0;
								row <= row + 7'd2;
							end else begin
								col <= '0;
								row <= '0;
								base <= base + mat_words + cnn_pkg::addr_t'(1);
								state <= ST_SIZE_RD;
							end
						end
					end
				end
				ST_DONE: begin
					// Wait for the writer to drain every started matrix
					if (started == written) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Credits and link strobes
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			credits <= CREDIT_W'(`CNN_PATCH_CREDITS);
			word_valid_q <= 1'b0;
			patch_last_q <= 1'b0;
			mend_d <= 1'b0;
			matrix_end_q <= 1'b0;
		end else begin
			credits <= credits + CREDIT_W'(patch.credit_return) - CREDIT_W'(take);
			// Read data lands one cycle after the address
			word_valid_q <= issue;
			patch_last_q <= issue && last_word;
			mend_d <= issue && last_word && col_last && row_last;
			matrix_end_q <= mend_d;
		end
	end

	assign patch.word_valid = word_valid_q;
	assign patch.word = in_data;
	assign patch.patch_last = patch_last_q;
	assign patch.matrix_end = matrix_end_q;

endmodule

// File: conv/conv_engine.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module conv_engine (
	input  logic clk,
	input  logic reset_b,
	patch_if.sink patch,
	output cnn_pkg::addr_t w_addr,
	input  cnn_pkg::word_t w_data,
	output logic sums_valid,
	output cnn_pkg::acc_quad_t sums,
	output logic matrix_end
);

	// 4x4 patch, index is 4*row + col
	cnn_pkg::pixel_t pix_buf [16];
	cnn_pkg::pixel_t weight;
	logic signed [2*`CNN_PIXEL_W-1:0] prod [4];
	logic [3:0] tap;
	logic [3:0] tap_base;
	logic mac_active;
	logic last_tap;
	logic end_pending;

	// ------------------------------------------------------------
	// Patch buffer
	// ------------------------------------------------------------
	// Words shift in two bytes at a time, oldest ends at index 0
	// The left pixel of each pair sits in the high byte
	always_ff @(posedge clk) begin
		if (patch.word_valid) begin
			for (int i = 0; i < 14; i++) begin
				pix_buf[i] <= pix_buf[i + 2];
			end
			pix_buf[14] <= patch.word[15:8];
			pix_buf[15] <= patch.word[7:0];
		end
	end

	// ------------------------------------------------------------
	// Kernel sequencing
	// ------------------------------------------------------------
	assign last_tap = (tap == 4'(`CNN_KERNEL_TAPS - 1));

	// Weight for tap k is requested one cycle ahead of its MAC
	// While idle the address rests on tap 0
	assign w_addr = mac_active ? cnn_pkg::addr_t'((tap + 4'd1) >> 1) : '0;

	// Even taps use the low byte
	assign weight = tap[0] ? w_data[15:8] : w_data[7:0];

	// Patch position of tap k for the (0,0) window
	always_comb begin
		case (tap)
			4'd0:    tap_base = 4'd0;
			4'd1:    tap_base = 4'd1;
			4'd2:    tap_base = 4'd2;
			4'd3:    tap_base = 4'd4;
			4'd4:    tap_base = 4'd5;
			4'd5:    tap_base = 4'd6;
			4'd6:    tap_base = 4'd8;
			4'd7:    tap_base = 4'd9;
			default: tap_base = 4'd10;
		endcase
	end

	// Same weight against the four shifted windows
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			prod[i] = pix_buf[tap_base + 4'(((i / 2) * 4) + (i % 2))] * weight;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			mac_active <= 1'b0;
			tap <= '0;
		end else begin
			if (patch.word_valid && patch.patch_last) begin
				mac_active <= 1'b1;
				tap <= '0;
			end else if (mac_active) begin
				if (last_tap) begin
					mac_active <= 1'b0;
				end else begin
					tap <= tap + 4'd1;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// Multiply-accumulate
	// ------------------------------------------------------------
	// Tap 0 starts a fresh sum
	always_ff @(posedge clk) begin
		if (mac_active) begin
			for (int i = 0; i < 4; i++) begin
				if (tap == 4'd0) begin
					sums[i] <= cnn_pkg::acc_t'(prod[i]);
				end else begin
					sums[i] <= sums[i] + cnn_pkg::acc_t'(prod[i]);
				end
			end
		end
	end

	// ------------------------------------------------------------
	// Result strobes
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			sums_valid <= 1'b0;
			end_pending <= 1'b0;
			matrix_end <= 1'b0;
		end else begin
			sums_valid <= mac_active && last_tap;
			// Matrix end trails the sums of its last patch by a cycle
			matrix_end <= sums_valid && end_pending;
			if (patch.matrix_end) begin
				end_pending <= 1'b1;
			end else if (sums_valid) begin
				end_pending <= 1'b0;
			end
		end
	end

	// Slot is free once the sums are out
	assign patch.credit_return = sums_valid;

endmodule

// File: rtl/pool_relu_writer.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module pool_relu_writer (
	input  logic clk,
	input  logic reset_b,
	input  logic sums_valid,
	input  cnn_pkg::acc_quad_t sums,
	input  logic matrix_end,
	input  logic busy,
	output logic out_we,
	output cnn_pkg::addr_t out_addr,
	output cnn_pkg::word_t out_data,
	output logic matrix_written
);

	cnn_pkg::acc_t max_lo;
	cnn_pkg::acc_t max_hi;
	cnn_pkg::acc_t max_r;
	logic valid_r;
	logic [7:0] relu;
	logic [7:0] held;
	logic pending;
	logic end_d;
	logic wr_en;
	logic hold_new;
	cnn_pkg::word_t wr_data;

	// 2x2 max pool
	assign max_lo = (sums[0] > sums[1]) ? sums[0] : sums[1];
	assign max_hi = (sums[2] > sums[3]) ? sums[2] : sums[3];

	always_ff @(posedge clk) begin
		if (sums_valid) begin
			max_r <= (max_lo > max_hi) ? max_lo : max_hi;
		end
	end

	// ReLU clamp to 0..127
	always_comb begin
		if (max_r < 0) begin
			relu = 8'd0;
		end else if (max_r > `CNN_RELU_MAX) begin
			relu = 8'(`CNN_RELU_MAX);
		end else begin
			relu = max_r[7:0];
		end
	end

	// ------------------------------------------------------------
	// Byte pairing, older result in the high byte
	// ------------------------------------------------------------
	always_comb begin
		wr_en = 1'b0;
		hold_new = 1'b0;
		wr_data = {held, relu};
		if (valid_r) begin
			if (pending) begin
				wr_en = 1'b1;
			end else if (matrix_end) begin
				wr_en = 1'b1;
				wr_data = {relu, 8'h00};
			end else begin
				hold_new = 1'b1;
			end
		end else if (matrix_end && pending) begin
			wr_en = 1'b1;
			wr_data = {held, 8'h00};
		end
	end

	always_ff @(posedge clk) begin
		if (hold_new) begin
			held <= relu;
		end
		if (wr_en) begin
			out_data <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			valid_r <= 1'b0;
			pending <= 1'b0;
			out_we <= 1'b0;
			out_addr <= '0;
			end_d <= 1'b0;
			matrix_written <= 1'b0;
		end else begin
			valid_r <= sums_valid;
			out_we <= wr_en;
			if (hold_new) begin
				pending <= 1'b1;
			end else if (wr_en) begin
				pending <= 1'b0;
			end
			// Output addresses restart with every run
			if (!busy) begin
				out_addr <= '0;
			end else if (out_we) begin
				out_addr <= out_addr + 1'b1;
			end
			end_d <= matrix_end;
			matrix_written <= end_d;
		end
	end

endmodule

// File: rtl/cnn_accel.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_accel (
	input  logic clk,
	input  logic reset_b,
	input  logic run,
	output logic busy,

	// Input SRAM, read only
	output logic [`CNN_ADDR_W-1:0] input_sram_read_address,
	input  logic [`CNN_DATA_W-1:0] input_sram_read_data,

	// Weights SRAM, read only
	output logic [`CNN_ADDR_W-1:0] weights_sram_read_address,
	input  logic [`CNN_DATA_W-1:0] weights_sram_read_data,

	// Output SRAM, write only
	output logic output_sram_write_enable,
	output logic [`CNN_ADDR_W-1:0] output_sram_write_address,
	output logic [`CNN_DATA_W-1:0] output_sram_write_data
);

	logic sums_valid;
	cnn_pkg::acc_quad_t sums;
	logic matrix_end;
	logic matrix_written;

	patch_if patch_link ();

	// ------------------------------------------------------------
	// Fetch, convolve, pool and write
	// ------------------------------------------------------------
	patch_fetcher u_fetcher (
		.clk            (clk),
		.reset_b        (reset_b),
		.run            (run),
		.busy           (busy),
		.in_addr        (input_sram_read_address),
		.in_data        (input_sram_read_data),
		.matrix_written (matrix_written),
		.patch          (patch_link.source)
	);

	conv_engine u_engine (
		.clk        (clk),
		.reset_b    (reset_b),
		.patch      (patch_link.sink),
		.w_addr     (weights_sram_read_address),
		.w_data     (weights_sram_read_data),
		.sums_valid (sums_valid),
		.sums       (sums),
		.matrix_end (matrix_end)
	);

	pool_relu_writer u_writer (
		.clk            (clk),
		.reset_b        (reset_b),
		.sums_valid     (sums_valid),
		.sums           (sums),
		.matrix_end     (matrix_end),
		.busy           (busy),
		.out_we         (output_sram_write_enable),
		.out_addr       (output_sram_write_address),
		.out_data       (output_sram_write_data),
		.matrix_written (matrix_written)
	);

endmodule

// File: verification/sram_model.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module sram_model (
	input  logic clk,
	input  logic [`CNN_ADDR_W-1:0] addr,
	output logic [`CNN_DATA_W-1:0] data
);

	// Contents loaded by the testbench between runs
	logic [`CNN_DATA_W-1:0] mem [1 << `CNN_ADDR_W];

	// Read data appears one cycle after the address
	always_ff @(posedge clk) begin
		data <= mem[addr];
	end

endmodule

// File: verification/cnn_tb.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_tb;

	localparam int MEM_WORDS = 1 << `CNN_ADDR_W;
	localparam int CLK_PERIOD = 8;
	localparam logic [1:0] PIX_SIGNED = 2'd0;
	localparam logic [1:0] PIX_POSITIVE = 2'd1;
	localparam logic [1:0] KERN_FIXED = 2'd0;
	localparam logic [1:0] KERN_RANDOM = 2'd1;

	// Sizes one per byte from the top, a zero byte ends the list
	// Kernel tap 0 sits in the low byte
	typedef struct packed {
		logic [31:0] sizes;
		logic [1:0] pix_mode;
		logic [1:0] kern_mode;
		logic [71:0] kern;
	} row_t;

	localparam int NUM_ROWS = 8;
	localparam row_t STIM [NUM_ROWS] = '{
		// Single 4x4, edge kernel 1 0 -1 / 2 0 -2 / 1 0 -1
		'{32'h04000000, PIX_SIGNED, KERN_FIXED, 72'hFF_00_01_FE_00_02_FF_00_01},
		'{32'h08000000, PIX_SIGNED, KERN_RANDOM, 72'h0},
		// Negative kernel on positive pixels, clamps low
		'{32'h08000000, PIX_POSITIVE, KERN_FIXED, 72'hF0_F0_F0_F0_F0_F0_F0_F0_F0},
		// Large positive sums, clamps high
		'{32'h08000000, PIX_POSITIVE, KERN_FIXED, 72'h7F_7F_7F_7F_7F_7F_7F_7F_7F},
		'{32'h04200804, PIX_SIGNED, KERN_RANDOM, 72'h0},
		// Terminator only
		'{32'h00000000, PIX_SIGNED, KERN_RANDOM, 72'h0},
		'{32'h40000000, PIX_SIGNED, KERN_RANDOM, 72'h0},
		'{32'h04000000, PIX_SIGNED, KERN_RANDOM, 72'h0}
	};

	logic clk;
	logic reset_b;
	logic run;
	logic busy;
	logic [`CNN_ADDR_W-1:0] in_addr;
	logic [`CNN_DATA_W-1:0] in_data;
	logic [`CNN_ADDR_W-1:0] w_addr;
	logic [`CNN_DATA_W-1:0] w_data;
	logic out_we;
	logic [`CNN_ADDR_W-1:0] out_addr;
	logic [`CNN_DATA_W-1:0] out_data;

	logic [15:0] lfsr_state;
	logic [15:0] in_img [MEM_WORDS];
	logic [15:0] w_img [MEM_WORDS];
	logic [15:0] got_words [$];
	logic [15:0] exp_words [$];

	cnn_accel dut (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.run                       (run),
		.busy                      (busy),
		.input_sram_read_address   (in_addr),
		.input_sram_read_data      (in_data),
		.weights_sram_read_address (w_addr),
		.weights_sram_read_data    (w_data),
		.output_sram_write_enable  (out_we),
		.output_sram_write_address (out_addr),
		.output_sram_write_data    (out_data)
	);

	sram_model in_mem (.clk(clk), .addr(in_addr), .data(in_data));
	sram_model w_mem (.clk(clk), .addr(w_addr), .data(w_data));

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	task automatic check_value(input int actual, input int expected, input string what);
		assert (actual == expected) else begin
			$display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("=== FAIL ===");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
		return b;
	endfunction

	function automatic logic [7:0] pixel_byte(input logic [1:0] mode);
		return (mode == PIX_POSITIVE) ? (random_byte() & 8'h7F) : random_byte();
	endfunction

	// Background fill, bytes stay non-negative
	function automatic logic [15:0] fill_word(input int a, input logic [15:0] salt);
		return ({1'b0, a[11:5], 1'b0, a[6:0]} ^ salt) & 16'h7F7F;
	endfunction

	task automatic build_images(input row_t row);
		int base;
		int n;
		logic [7:0] kb [9];
		for (int a = 0; a < MEM_WORDS; a++) begin
			in_img[a] = fill_word(a, 16'h2C4B);
			w_img[a] = fill_word(a, 16'h5193);
		end
		for (int k = 0; k < `CNN_KERNEL_TAPS; k++) begin
			kb[k] = (row.kern_mode == KERN_FIXED) ? row.kern[8*k +: 8] : random_byte();
		end
		// Odd taps high, even taps low
		for (int j = 0; j < 4; j++) begin
			w_img[j] = {kb[2*j + 1], kb[2*j]};
		end
		w_img[4][7:0] = kb[8];
		base = 0;
		for (int m = 0; m < 4; m++) begin
			n = int'(row.sizes[31 - 8*m -: 8]);
			if (n == 0) begin
				break;
			end
			in_img[base] = 16'(n);
			for (int w = 1; w <= n * n / 2; w++) begin
				in_img[base + w][15:8] = pixel_byte(row.pix_mode);
				in_img[base + w][7:0] = pixel_byte(row.pix_mode);
			end
			base += n * n / 2 + 1;
		end
		in_img[base] = `CNN_TERMINATOR;
		for (int a = 0; a < MEM_WORDS; a++) begin
			in_mem.mem[a] = in_img[a];
			w_mem.mem[a] = w_img[a];
		end
	endtask

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	// Pixel s of the row-major stream after the size word, left pixel high
	function automatic int pixel_at(input int base, input int s);
		logic [15:0] w;
		w = in_img[(base + 1 + s / 2) % MEM_WORDS];
		return (s % 2 == 0) ? int'($signed(w[15:8])) : int'($signed(w[7:0]));
	endfunction

	function automatic int weight_at(input int k);
		logic [15:0] w;
		w = w_img[k / 2];
		return (k % 2 == 0) ? int'($signed(w[7:0])) : int'($signed(w[15:8]));
	endfunction

	task automatic build_expected();
		int base;
		int n;
		int sum;
		int best;
		logic [7:0] results [$];
		exp_words.delete();
		base = 0;
		while (in_img[base] != `CNN_TERMINATOR) begin
			n = int'(in_img[base]);
			results.delete();
			// Valid outputs span N-2 positions, pooled in 2x2 blocks
			for (int row = 0; row < n - 2; row += 2) begin
				for (int col = 0; col < n - 2; col += 2) begin
					best = 0;
					for (int win = 0; win < 4; win++) begin
						sum = 0;
						for (int k = 0; k < `CNN_KERNEL_TAPS; k++) begin
							sum += weight_at(k) * pixel_at(base,
								n * (row + win / 2 + k / 3) + col + win % 2 + k % 3);
						end
						if (win == 0 || sum > best) begin
							best = sum;
						end
					end
					if (best < 0) begin
						best = 0;
					end else if (best > `CNN_RELU_MAX) begin
						best = `CNN_RELU_MAX;
					end
					results.push_back(8'(best));
				end
			end
			// Older result high, a lone last byte gets a zero partner
			for (int i = 0; i < results.size(); i += 2) begin
				exp_words.push_back({results[i], (i + 1 < results.size()) ? results[i + 1] : 8'h00});
			end
			base += n * n / 2 + 1;
		end
	endtask

	function automatic int table_patches();
		int total;
		int n;
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int m = 0; m < 4; m++) begin
				n = int'(STIM[r].sizes[31 - 8*m -: 8]);
				if (n != 0) begin
					total += (n / 2 - 1) * (n / 2 - 1);
				end
			end
		end
		return total;
	endfunction

	// ------------------------------------------------------------
	// Output capture and watchdog
	// ------------------------------------------------------------
	always @(posedge clk) begin
		if (out_we) begin
			check_value(out_addr, got_words.size(), "output write address");
			got_words.push_back(out_data);
		end
	end

	initial begin
		longint limit;
		limit = (longint'(table_patches()) * 200 + NUM_ROWS * 20 + 1000) * CLK_PERIOD;
		#(limit);
		$display("ERROR at %0d ns: timeout, busy did not fall within the cycle budget", $time);
		$display("=== FAIL ===");
		$fatal(1, "Watchdog expired");
	end

	// ------------------------------------------------------------
	// Table-driven runs
	// ------------------------------------------------------------
	initial begin
		int cycles;
		lfsr_state = 16'd28329;
		reset_b = 1'b0;
		run = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset_b = 1'b1;
		check_value(busy, 0, "busy after reset");
		check_value(out_we, 0, "write enable after reset");
		for (int r = 0; r < NUM_ROWS; r++) begin
			build_images(STIM[r]);
			build_expected();
			got_words.delete();
			@(posedge clk);
			#1;
			run = 1'b1;
			@(posedge clk);
			#1;
			run = 1'b0;
			check_value(busy, 1, "busy one cycle after run");
			cycles = 0;
			while (busy) begin
				@(posedge clk);
				#1;
				cycles++;
			end
			if (STIM[r].sizes == 32'h0) begin
				check_value(int'(cycles <= 8), 1, "busy drop on an empty list within 8 cycles");
			end
			check_value(got_words.size(), exp_words.size(), $sformatf("word count of row %0d", r));
			foreach (exp_words[i]) begin
				check_value(got_words[i], exp_words[i], $sformatf("word %0d of row %0d", i, r));
			end
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: sources.f
+incdir+common
common/cnn_pkg.sv
common/patch_if.sv
fetch/patch_fetcher.sv
conv/conv_engine.sv
rtl/pool_relu_writer.sv
rtl/cnn_accel.sv
verification/sram_model.sv
verification/cnn_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f sources.f --top-module cnn_tb -o cnn_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cnn_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
